//--- common/knight_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared definitions for the knight command processing unit.
// FAST_SIM selects large ramp and nudge steps for short simulations.
// Clear it for the real robot timing.
////////////////////////////////////////////////////////////////////////////

package knight_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Command word layout
  ////////////////////////////////////////////////////////////////////////////

  localparam int OP_MSB  = 15;  // Opcode field, top nibble.
  localparam int OP_LSB  = 12;
  localparam int HDG_MSB = 11;  // Heading byte.
  localparam int HDG_LSB = 4;
  localparam int SQ_MSB  = 3;   // Square count nibble.
  localparam int SQ_LSB  = 0;

  // Opcodes decoded by the FSM. Unlisted values fall through as a move.
  typedef enum logic [3:0] {
    CAL     = 4'h2,  // Gyro calibration.
    MOV     = 4'h4,  // Plain move.
    FANFARE = 4'h5,  // Move, then kick the fanfare.
    TOUR    = 4'h6   // Hand off to the tour engine.
  } op_t;

  // Command FSM states.
  typedef enum logic [2:0] {
    IDLE,       // Waiting on cmd_rdy.
    CALIBRATE,  // Waiting on cal_done.
    MOVE,       // Turning onto the desired heading.
    INCR,       // Ramping up and travelling.
    DECR        // Ramping down to a stop.
  } state_t;

  ////////////////////////////////////////////////////////////////////////////
  // Speed and nudge constants
  ////////////////////////////////////////////////////////////////////////////

  localparam bit FAST_SIM = 1'b1;  // Large steps for simulation.

  // Forward speed steps, applied once per heading_rdy.
  localparam logic [9:0] INC_AMT = FAST_SIM ? 10'h020 : 10'h003;
  localparam logic [9:0] DEC_AMT = FAST_SIM ? 10'h040 : 10'h006;

  // Error offsets when a side IR sensor sees a line.
  localparam logic signed [11:0] NUDGE_POS = FAST_SIM ? 12'sh1FF : 12'sh05F;
  localparam logic signed [11:0] NUDGE_NEG = FAST_SIM ? 12'shE00 : 12'shFA1;

  // Heading must be this close before travel starts.
  localparam logic [11:0] HEADING_WIN = 12'h02C;

endpackage

//--- cmd_proc/cmd_fsm.sv
////////////////////////////////////////////////////////////////////////////
// Command decode FSM. Outputs are combinational and default low.
// A command is consumed only in IDLE, so a new one stays pending on
// cmd_rdy while a move or calibration is in progress.
// move_cmd is held for all of MOVE, which reloads the data blocks.
////////////////////////////////////////////////////////////////////////////

module cmd_fsm import knight_pkg::*; (
  input  logic clk,          // System clock.
  input  logic rst_n,        // Async reset, active low.
  input  logic cmd_rdy,      // Command waiting.
  input  logic cal_done,     // Gyro calibration finished.
  input  op_t  opcode,       // Decoded command opcode.
  input  logic move_done,    // All lines of the move crossed.
  input  logic at_zero,      // Forward speed is zero.
  input  logic in_window,    // Heading error small enough.
  output logic clr_cmd_rdy,  // Command consumed.
  output logic send_resp,    // Command complete.
  output logic strt_cal,     // Kick gyro calibration.
  output logic tour_go,      // Kick the tour engine.
  output logic fanfare_go,   // Kick the fanfare.
  output logic moving,       // Robot under way.
  output logic move_cmd,     // Reload square count and heading.
  output logic clr_frwrd,    // Zero the speed register.
  output logic inc_frwrd,    // Ramp speed up.
  output logic dec_frwrd     // Ramp speed down.
);

  state_t state;      // Current state.
  state_t nxt_state;  // Next state.

  ////////////////////////////////////////////////////////////////////////////
  // State register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;       // Come up idle.
    end else begin
      state <= nxt_state;  // Advance.
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    nxt_state   = state;  // Hold by default.
    clr_cmd_rdy = 1'b0;
    send_resp   = 1'b0;
    strt_cal    = 1'b0;
    tour_go     = 1'b0;
    fanfare_go  = 1'b0;
    moving      = 1'b0;
    move_cmd    = 1'b0;
    clr_frwrd   = 1'b0;
    inc_frwrd   = 1'b0;
    dec_frwrd   = 1'b0;

    case (state)
      CALIBRATE: begin
        if (cal_done) begin
          send_resp = 1'b1;  // Calibration acknowledged.
          nxt_state = IDLE;
        end
      end

      MOVE: begin
        move_cmd = 1'b1;  // Keep reloading targets.
        if (in_window) begin
          clr_frwrd = 1'b1;  // Start ramp from rest.
          moving    = 1'b1;
          nxt_state = INCR;
        end
      end

      INCR: begin
        inc_frwrd = 1'b1;  // Ramp up toward the ceiling.
        moving    = 1'b1;
        if (move_done) begin
          nxt_state = DECR;  // Last line crossed.
          if (opcode == FANFARE) begin
            fanfare_go = 1'b1;  // Single pulse at ramp-down.
          end
        end
      end

      DECR: begin
        dec_frwrd = 1'b1;  // Ramp down, clamps at zero.
        if (at_zero) begin
          send_resp = 1'b1;  // Stopped, move complete.
          nxt_state = IDLE;
        end else begin
          moving = 1'b1;
        end
      end

      default: begin  // IDLE.
        if (cmd_rdy) begin
          clr_cmd_rdy = 1'b1;  // Every opcode is consumed.
          case (opcode)
            CAL: begin
              strt_cal  = 1'b1;
              nxt_state = CALIBRATE;
            end
            TOUR: begin
              tour_go = 1'b1;  // Stays idle.
            end
            default: begin
              nxt_state = MOVE;  // MOV, FANFARE and unknown codes.
            end
          endcase
        end
      end
    endcase
  end

endmodule

//--- cmd_proc/square_counter.sv
////////////////////////////////////////////////////////////////////////////
// Board line counter. cntr_ir is asynchronous and passes two flops.
// A rising edge is counted 3 cycles after the input edge.
// Two lines per square, so up to 15 squares fit the 5-bit count.
////////////////////////////////////////////////////////////////////////////

module square_counter (
  input  logic       clk,        // System clock.
  input  logic       rst_n,      // Async reset, active low.
  input  logic       cntr_ir,    // Centre IR, async level.
  input  logic       move_cmd,   // Load target, clear count.
  input  logic [3:0] squares,    // Requested square count.
  output logic       move_done   // Count reached target.
);

  logic       ir_meta;     // First synchronizer stage.
  logic       ir_sync;     // Second synchronizer stage.
  logic       ir_prev;     // Delayed copy for edge detect.
  logic       ir_rise;     // Rising edge seen.
  logic [3:0] square_cnt;  // Latched target.
  logic [4:0] pulse_cnt;   // Lines crossed so far.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ir_meta <= 1'b0;
      ir_sync <= 1'b0;
      ir_prev <= 1'b0;
    end else begin
      ir_meta <= cntr_ir;  // May go metastable.
      ir_sync <= ir_meta;  // Safe to use.
      ir_prev <= ir_sync;
    end
  end

  assign ir_rise = ir_sync & ~ir_prev;  // Low to high.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      square_cnt <= 4'h0;
      pulse_cnt  <= 5'h00;
    end else if (move_cmd) begin
      square_cnt <= squares;  // Capture target.
      pulse_cnt  <= 5'h00;    // Fresh count.
    end else if (ir_rise) begin
      pulse_cnt <= pulse_cnt + 5'h01;
    end
  end

  // Each square spans two lines.
  assign move_done = (pulse_cnt == {square_cnt, 1'b0});

endmodule

//--- cmd_proc/speed_ramp.sv
////////////////////////////////////////////////////////////////////////////
// Forward speed register for the PID. Steps only on heading_rdy.
// Ceiling is reached once both top bits are set.
// clr_frwrd takes effect regardless of heading_rdy.
////////////////////////////////////////////////////////////////////////////

module speed_ramp import knight_pkg::*; (
  input  logic       clk,          // System clock.
  input  logic       rst_n,        // Async reset, active low.
  input  logic       heading_rdy,  // New gyro reading, 1 cycle.
  input  logic       clr_frwrd,    // Zero the speed.
  input  logic       inc_frwrd,    // Ramp up.
  input  logic       dec_frwrd,    // Ramp down.
  output logic [9:0] frwrd,        // Forward speed word.
  output logic       at_zero       // Speed is zero.
);

  logic max_spd;  // Ceiling reached.
  logic dec_end;  // Next step would pass zero.

  assign max_spd = &frwrd[9:8];
  assign at_zero = (frwrd == 10'h000);
  assign dec_end = (frwrd <= DEC_AMT);

  ////////////////////////////////////////////////////////////////////////////
  // Speed register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frwrd <= 10'h000;
    end else if (clr_frwrd) begin
      frwrd <= 10'h000;  // Start of a move.
    end else if (heading_rdy) begin
      if (inc_frwrd) begin
        if (!max_spd) begin
          frwrd <= frwrd + INC_AMT;  // Lands on the ceiling exactly.
        end
      end else if (dec_frwrd) begin
        if (dec_end) begin
          frwrd <= 10'h000;  // Clamp.
        end else begin
          frwrd <= frwrd - DEC_AMT;
        end
      end
    end
  end

endmodule

//--- cmd_proc/heading_error.sv
////////////////////////////////////////////////////////////////////////////
// Heading error for the PID. error is combinational from heading.
// Desired heading reloads every cycle move_cmd is high.
// Side IR inputs are asynchronous and pass two flops.
// Left nudge wins when both side sensors see a line.
////////////////////////////////////////////////////////////////////////////

module heading_error import knight_pkg::*; (
  input  logic               clk,           // System clock.
  input  logic               rst_n,         // Async reset, active low.
  input  logic               lft_ir,        // Left IR, async level.
  input  logic               rght_ir,       // Right IR, async level.
  input  logic               move_cmd,      // Reload desired heading.
  input  logic        [7:0]  heading_code,  // Heading byte of command.
  input  logic signed [11:0] heading,       // Gyro heading.
  output logic signed [11:0] error,         // Heading error with nudge.
  output logic               in_window      // Error inside HEADING_WIN.
);

  logic        [1:0]  side_meta;     // First stage, {left, right}.
  logic        [1:0]  side_sync;     // Second stage, {left, right}.
  logic signed [11:0] desired_hdg;   // Latched target heading.
  logic signed [11:0] err_nudge;     // Line-following offset.
  logic        [11:0] error_abs;     // Magnitude of error.

  ////////////////////////////////////////////////////////////////////////////
  // Side sensor synchronizers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      side_meta <= 2'b00;
      side_sync <= 2'b00;
    end else begin
      side_meta <= {lft_ir, rght_ir};  // May go metastable.
      side_sync <= side_meta;
    end
  end

  assign err_nudge = side_sync[1] ? NUDGE_POS :  // Drifted left.
                     side_sync[0] ? NUDGE_NEG :  // Drifted right.
                     12'sh000;

  ////////////////////////////////////////////////////////////////////////////
  // Desired heading
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      desired_hdg <= 12'sh000;
    end else if (move_cmd) begin
      if (heading_code == 8'h00) begin
        desired_hdg <= 12'sh000;  // North is exactly zero.
      end else begin
        desired_hdg <= {heading_code, 4'hF};  // Pad low nibble.
      end
    end
  end

  // Error and window check.
  assign error     = heading - desired_hdg + err_nudge;
  assign error_abs = error[11] ? -error : error;
  assign in_window = (error_abs < HEADING_WIN);

endmodule

//--- verilog/knight_cmd_top.sv
////////////////////////////////////////////////////////////////////////////
// Command processing unit of the knight robot.
// cmd and cmd_rdy come from the Bluetooth receiver and are held until
// clr_cmd_rdy. error and frwrd feed an external PID.
// IR inputs may be asynchronous, they are synchronized inside.
////////////////////////////////////////////////////////////////////////////

module knight_cmd_top import knight_pkg::*; (
  input  logic               clk,          // System clock.
  input  logic               rst_n,        // Async reset, active low.
  input  logic        [15:0] cmd,          // Command word.
  input  logic               cmd_rdy,      // Command waiting.
  input  logic               cal_done,     // Gyro calibration finished.
  input  logic signed [11:0] heading,      // Gyro heading.
  input  logic               heading_rdy,  // New heading, 1 cycle.
  input  logic               lft_ir,       // Left IR sensor.
  input  logic               cntr_ir,      // Centre IR sensor.
  input  logic               rght_ir,      // Right IR sensor.
  output logic               clr_cmd_rdy,  // Command consumed.
  output logic               send_resp,    // Command complete.
  output logic               strt_cal,     // Kick gyro calibration.
  output logic               tour_go,      // Kick tour engine.
  output logic               fanfare_go,   // Kick fanfare.
  output logic               moving,       // Robot under way.
  output logic signed [11:0] error,        // Heading error to PID.
  output logic        [9:0]  frwrd         // Forward speed to PID.
);

  op_t        opcode;        // Command opcode.
  logic [7:0] heading_code;  // Command heading byte.
  logic [3:0] squares;       // Command square count.
  logic       move_cmd;      // Reload targets.
  logic       clr_frwrd;
  logic       inc_frwrd;
  logic       dec_frwrd;
  logic       move_done;     // Target line count reached.
  logic       at_zero;       // Speed at zero.
  logic       in_window;     // Heading aligned.

  // Command fields.
  assign opcode       = op_t'(cmd[OP_MSB:OP_LSB]);
  assign heading_code = cmd[HDG_MSB:HDG_LSB];
  assign squares      = cmd[SQ_MSB:SQ_LSB];

  cmd_fsm fsm0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_rdy     (cmd_rdy),
    .cal_done    (cal_done),
    .opcode      (opcode),
    .move_done   (move_done),
    .at_zero     (at_zero),
    .in_window   (in_window),
    .clr_cmd_rdy (clr_cmd_rdy),
    .send_resp   (send_resp),
    .strt_cal    (strt_cal),
    .tour_go     (tour_go),
    .fanfare_go  (fanfare_go),
    .moving      (moving),
    .move_cmd    (move_cmd),
    .clr_frwrd   (clr_frwrd),
    .inc_frwrd   (inc_frwrd),
    .dec_frwrd   (dec_frwrd)
  );

  square_counter sqc0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cntr_ir   (cntr_ir),
    .move_cmd  (move_cmd),
    .squares   (squares),
    .move_done (move_done)
  );

  speed_ramp spd0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .heading_rdy (heading_rdy),
    .clr_frwrd   (clr_frwrd),
    .inc_frwrd   (inc_frwrd),
    .dec_frwrd   (dec_frwrd),
    .frwrd       (frwrd),
    .at_zero     (at_zero)
  );

  heading_error hdg0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .lft_ir       (lft_ir),
    .rght_ir      (rght_ir),
    .move_cmd     (move_cmd),
    .heading_code (heading_code),
    .heading      (heading),
    .error        (error),
    .in_window    (in_window)
  );

endmodule

//--- verification/knight_cmd_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the knight command unit. A cycle model of the FSM, speed
// ramp, line counter and heading error is compared with the DUT at every
// falling edge. Expects FAST_SIM constants for the move lengths used.
////////////////////////////////////////////////////////////////////////////

module knight_cmd_tb import knight_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_NS      = 10;
  localparam int MOVE_CYCLES = 400;  // Longest move with ramp up and down.
  localparam int NUM_MOVES   = 9;
  localparam int MISC_CYCLES = 200;  // Reset, tour and calibration.
  localparam int WATCHDOG_NS = 2 * (NUM_MOVES * MOVE_CYCLES + MISC_CYCLES) * CLK_NS;

  logic               clk;
  logic               rst_n;
  logic        [15:0] cmd;
  logic               cmd_rdy;
  logic               cal_done;
  logic signed [11:0] heading;
  logic               heading_rdy = 1'b0;  // Driven by the gyro model.
  logic               lft_ir;
  logic               cntr_ir;
  logic               rght_ir;
  logic               clr_cmd_rdy;
  logic               send_resp;
  logic               strt_cal;
  logic               tour_go;
  logic               fanfare_go;
  logic               moving;
  logic signed [11:0] error;
  logic        [9:0]  frwrd;

  // Reference model state.
  state_t             m_state;
  logic        [9:0]  m_frwrd;
  logic signed [11:0] m_desired;
  logic        [3:0]  m_sq;
  logic        [4:0]  m_pulse;
  logic        [2:0]  m_cntr;     // {prev, sync, meta}.
  logic        [1:0]  m_lft;      // {sync, meta}.
  logic        [1:0]  m_rght;
  logic        [1:0]  gyro_cnt = 2'd0;

  int    errors = 0;
  string test_name = "reset";
  int    cnt_clr = 0;
  int    cnt_resp = 0;
  int    cnt_cal = 0;
  int    cnt_tour = 0;
  int    cnt_fanfare = 0;
  int    cnt_moving = 0;

  knight_cmd_top dut0 (.*);

  always #(CLK_NS / 2) clk = ~clk;

  // Gyro model gives a new heading every fourth cycle.
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gyro_cnt    <= 2'd0;
      heading_rdy <= 1'b0;
    end else begin
      gyro_cnt    <= gyro_cnt + 2'd1;
      heading_rdy <= (gyro_cnt == 2'd3);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic signed [11:0] desired_of(input logic [7:0] code);
    return (code == 8'h00) ? 12'sh000 : $signed({code, 4'hF});  // North is zero.
  endfunction

  function automatic logic signed [11:0] heading_err(input logic signed [11:0] hdg,
      input logic signed [11:0] want, input logic lft, input logic rght);
    logic signed [11:0] nudge;
    nudge = lft ? NUDGE_POS : (rght ? NUDGE_NEG : 12'sh000);  // Left first.
    return hdg - want + nudge;
  endfunction

  function automatic logic window_ok(input logic signed [11:0] err);
    int mag;
    mag = (err < 0) ? -int'(err) : int'(err);
    return mag < int'(HEADING_WIN);
  endfunction

  function automatic logic [9:0] frwrd_step(input logic [9:0] f, input logic rdy,
      input logic clr, input logic inc, input logic dec);
    if (clr) return 10'h000;
    if (rdy && inc && f < 10'h300) return f + INC_AMT;  // Ceiling at 0x300.
    if (rdy && dec) return (f > DEC_AMT) ? f - DEC_AMT : 10'h000;
    return f;
  endfunction

  // Expected {clr_cmd_rdy, send_resp, strt_cal, tour_go, fanfare_go, moving}.
  function automatic logic [5:0] out_pulses(input state_t st, input logic rdy, input op_t op,
      input logic cal, input logic win, input logic done, input logic zero);
    case (st)
      IDLE:      return rdy ? {1'b1, 1'b0, op == CAL, op == TOUR, 2'b00} : 6'b0;
      CALIBRATE: return {1'b0, cal, 4'b0};
      MOVE:      return {5'b0, win};
      INCR:      return {4'b0, done && op == FANFARE, 1'b1};
      default:   return {1'b0, zero, 3'b0, !zero};
    endcase
  endfunction

  function automatic state_t fsm_step(input state_t st, input logic rdy, input op_t op,
      input logic cal, input logic win, input logic done, input logic zero);
    case (st)
      IDLE:      if (rdy && op != TOUR) return (op == CAL) ? CALIBRATE : MOVE;
      CALIBRATE: if (cal) return IDLE;
      MOVE:      if (win) return INCR;
      INCR:      if (done) return DECR;
      default:   if (zero) return IDLE;
    endcase
    return st;
  endfunction

  task automatic compare(input string what, input int exp, input int act);
    assert (exp == act) else begin
      errors++;
      $display("MISMATCH %s %s expected %0d actual %0d at %0t",
               test_name, what, exp, act, $time);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Comparing process that advances the model once per cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : check_model
    logic signed [11:0] err;
    logic               win;
    logic               done;
    logic               zero;
    logic               rise;
    op_t                op;
    state_t             nxt;
    if (!rst_n) begin
      m_state   = IDLE;
      m_frwrd   = 10'h000;
      m_desired = 12'sh000;
      m_sq      = 4'h0;
      m_pulse   = 5'h00;
      m_cntr    = 3'b000;
      m_lft     = 2'b00;
      m_rght    = 2'b00;
    end else begin
      op   = op_t'(cmd[15:12]);
      err  = heading_err(heading, m_desired, m_lft[1], m_rght[1]);
      win  = window_ok(err);
      done = (int'(m_pulse) == 2 * int'(m_sq));  // Two lines per square.
      zero = (m_frwrd == 10'h000);
      compare("state", int'(m_state), int'(dut0.fsm0.state));
      compare("pulses", int'(out_pulses(m_state, cmd_rdy, op, cal_done, win, done, zero)),
              int'({clr_cmd_rdy, send_resp, strt_cal, tour_go, fanfare_go, moving}));
      compare("error", int'(err), int'(error));
      compare("frwrd", int'(m_frwrd), int'(frwrd));
      if (clr_cmd_rdy) cnt_clr++;
      if (send_resp) cnt_resp++;
      if (strt_cal) cnt_cal++;
      if (tour_go) cnt_tour++;
      if (fanfare_go) cnt_fanfare++;
      if (moving) cnt_moving++;
      nxt     = fsm_step(m_state, cmd_rdy, op, cal_done, win, done, zero);
      m_frwrd = frwrd_step(m_frwrd, heading_rdy, m_state == MOVE && win,
                           m_state == INCR, m_state == DECR);
      rise    = m_cntr[1] & ~m_cntr[2];
      if (m_state == MOVE) begin
        m_desired = desired_of(cmd[11:4]);  // Reloads all through MOVE.
        m_sq      = cmd[3:0];
        m_pulse   = 5'h00;
      end else if (rise) begin
        m_pulse = m_pulse + 5'h01;
      end
      m_cntr  = {m_cntr[1:0], cntr_ir};
      m_lft   = {m_lft[0], lft_ir};
      m_rght  = {m_rght[0], rght_ir};
      m_state = nxt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic clear_counts();
    cnt_clr     = 0;
    cnt_resp    = 0;
    cnt_cal     = 0;
    cnt_tour    = 0;
    cnt_fanfare = 0;
    cnt_moving  = 0;
  endtask

  task automatic wait_output(input string what, input int limit);
    int   n;
    logic hit;
    n   = 0;
    hit = 1'b0;
    while (!hit && n < limit) begin
      @(negedge clk);
      hit = (what == "clr_cmd_rdy") ? clr_cmd_rdy : (what == "moving") ? moving : send_resp;
      n++;
    end
    assert (hit) else begin
      errors++;
      $display("ERROR %s: %s did not rise within %0d cycles", test_name, what, limit);
    end
  endtask

  task automatic issue_cmd(input op_t op, input logic [7:0] code, input logic [3:0] sq);
    @(posedge clk);
    cmd     <= {op, code, sq};
    cmd_rdy <= 1'b1;
    wait_output("clr_cmd_rdy", 20);
    @(posedge clk);
    cmd_rdy <= 1'b0;  // Receiver drops the level.
  endtask

  task automatic side_nudge(input logic lft, input logic rght);
    @(posedge clk);
    lft_ir  <= lft;
    rght_ir <= rght;
    repeat (6) @(posedge clk);
    lft_ir  <= 1'b0;
    rght_ir <= 1'b0;
    repeat (3) @(posedge clk);
  endtask

  task automatic line_pulse();
    @(posedge clk);
    cntr_ir <= 1'b1;
    repeat (3) @(posedge clk);
    cntr_ir <= 1'b0;
    repeat (4) @(posedge clk);
  endtask

  task automatic travel(input logic [3:0] sq);
    repeat ($urandom_range(120, 20)) @(posedge clk);  // Often reaches the ceiling.
    side_nudge(1'b1, 1'b0);
    side_nudge(1'b0, 1'b1);
    side_nudge(1'b1, 1'b1);
    repeat (2 * sq) line_pulse();
    wait_output("send_resp", MOVE_CYCLES);
    repeat (2) @(posedge clk);
  endtask

  task automatic run_move(input op_t op, input logic [7:0] code, input logic [3:0] sq);
    int ofs;
    ofs = int'($urandom_range(80)) - 40;  // Inside the heading window.
    @(posedge clk);
    heading <= desired_of(code) + 12'(ofs);
    issue_cmd(op, code, sq);
    wait_output("moving", 10);
    travel(sq);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [7:0] code;
    void'($urandom(63));
    clk      = 1'b0;
    rst_n    = 1'b0;
    cmd      = 16'h0000;
    cmd_rdy  = 1'b0;
    cal_done = 1'b0;
    heading  = 12'sh000;
    lft_ir   = 1'b0;
    cntr_ir  = 1'b0;
    rght_ir  = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge clk);
    compare("frwrd after reset", 0, int'(frwrd));

    test_name = "tour";
    clear_counts();
    issue_cmd(TOUR, 8'h00, 4'h0);
    repeat (10) @(posedge clk);
    compare("tour_go pulses", 1, cnt_tour);
    compare("clr_cmd_rdy pulses", 1, cnt_clr);
    compare("send_resp pulses", 0, cnt_resp);

    test_name = "calibrate";
    clear_counts();
    issue_cmd(CAL, 8'h00, 4'h0);
    repeat (20) @(posedge clk);
    compare("send_resp before cal_done", 0, cnt_resp);
    cal_done <= 1'b1;
    wait_output("send_resp", 5);
    @(posedge clk);
    cal_done <= 1'b0;
    repeat (3) @(posedge clk);
    compare("strt_cal pulses", 1, cnt_cal);
    compare("send_resp pulses", 1, cnt_resp);

    for (int i = 0; i < 6; i++) begin
      code      = (i == 0) ? 8'h00 : 8'($urandom);
      test_name = $sformatf("move %0d squares code %02h", 1 + i % 4, code);
      clear_counts();
      run_move(MOV, code, 4'(1 + i % 4));
      compare("send_resp pulses", 1, cnt_resp);
      compare("fanfare_go pulses", 0, cnt_fanfare);
    end

    test_name = "fanfare";
    clear_counts();
    run_move(FANFARE, 8'hC0, 4'h2);
    compare("fanfare_go pulses", 1, cnt_fanfare);
    test_name = "move without fanfare";
    clear_counts();
    run_move(MOV, 8'h40, 4'h1);
    compare("fanfare_go pulses", 0, cnt_fanfare);

    test_name = "heading far";
    clear_counts();
    @(posedge clk);
    heading <= desired_of(8'h40) + 12'sh400;  // Well outside the window.
    issue_cmd(MOV, 8'h40, 4'h1);
    repeat (30) @(posedge clk);
    compare("moving cycles while turning", 0, cnt_moving);
    compare("frwrd while turning", 0, int'(frwrd));
    heading <= desired_of(8'h40) - 12'sh010;
    wait_output("moving", 10);
    travel(4'h1);

    $display("Checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired, the test sequence did not complete");
    $display("Checks done, %0d errors", errors);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- project.f
common/knight_pkg.sv
cmd_proc/cmd_fsm.sv
cmd_proc/square_counter.sv
cmd_proc/speed_ramp.sv
cmd_proc/heading_error.sv
verilog/knight_cmd_top.sv
verification/knight_cmd_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the knight command unit testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f project.f \
  --top-module knight_cmd_tb -o knight_sim

./obj_dir/knight_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"
